//--- nocPkg.sv
package nocPkg;

  // Flit field widths
  localparam int LenWidth = 12;
  localparam int IdWidth = 3;

  // Local plus four mesh neighbours
  localparam int NumPorts = 5;

  // Kind of flit carried in the id field
  typedef enum logic [IdWidth-1:0]
  {
    none = 3'd0,
    head = 3'd1,
    body = 3'd2,
    tail = 3'd3
  } flitIdT;

  // Router ports, listed in rotation order
  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portT;

endpackage

//--- arbPkg.sv
package arbPkg;

  // One-hot grant states, one per port plus idle
  typedef enum logic [5:0]
  {
    stIdle = 6'b000001,
    stL    = 6'b000010,
    stN    = 6'b000100,
    stE    = 6'b001000,
    stW    = 6'b010000,
    stS    = 6'b100000
  } arbStateT;

endpackage

//--- portTimer.sv
`timescale 1ns/1ps

module portTimer
  import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitIdT              flitId,
  input  logic [LenWidth-1:0] length,
  input  logic                runTimer,
  output logic                timesUp
);

  logic [LenWidth-1:0] holdLimit;
  logic [LenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
      count     <= '0;
    end
    else
    begin
      // Head flit carries the hold limit
      if (flitId == head)
        holdLimit <= length;
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == holdLimit);

endmodule

//--- switchArbiter.sv
`timescale 1ns/1ps

module switchArbiter
  import nocPkg::*;
  import arbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                lReq,
  input  flitIdT              lFlitId,
  input  logic [LenWidth-1:0] lLength,
  input  logic                nReq,
  input  flitIdT              nFlitId,
  input  logic [LenWidth-1:0] nLength,
  input  logic                eReq,
  input  flitIdT              eFlitId,
  input  logic [LenWidth-1:0] eLength,
  input  logic                wReq,
  input  flitIdT              wFlitId,
  input  logic [LenWidth-1:0] wLength,
  input  logic                sReq,
  input  flitIdT              sFlitId,
  input  logic [LenWidth-1:0] sLength,
  output arbStateT            state
);

  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;
  flitIdT              flitIds [NumPorts];
  logic [LenWidth-1:0] lengths [NumPorts];
  arbStateT            nextState;
  logic                isIdle;
  logic                found;
  int                  curIdx;
  int                  startIdx;
  int                  searchIdx;

  function automatic arbStateT toState(input int idx);
    arbStateT st;
    case (idx)
      0: st = stL;
      1: st = stN;
      2: st = stE;
      3: st = stW;
      default: st = stS;
    endcase
    return st;
  endfunction

  assign req = {sReq, wReq, eReq, nReq, lReq};

  assign flitIds[0] = lFlitId;
  assign flitIds[1] = nFlitId;
  assign flitIds[2] = eFlitId;
  assign flitIds[3] = wFlitId;
  assign flitIds[4] = sFlitId;

  assign lengths[0] = lLength;
  assign lengths[1] = nLength;
  assign lengths[2] = eLength;
  assign lengths[3] = wLength;
  assign lengths[4] = sLength;

  genvar p;
  generate
    for (p = 0; p < NumPorts; p++)
    begin : genTimer
      portTimer uTimer (
        .clk      (clk),
        .rst      (rst),
        .flitId   (flitIds[p]),
        .length   (lengths[p]),
        .runTimer (runTimer[p]),
        .timesUp  (timesUp[p])
      );
    end
  endgenerate

  always_comb
  begin
    isIdle = 1'b0;
    curIdx = 0;
    case (state)
      stL: curIdx = 0;
      stN: curIdx = 1;
      stE: curIdx = 2;
      stW: curIdx = 3;
      stS: curIdx = 4;
      default: isIdle = 1'b1;
    endcase
  end

  always_comb
  begin
    nextState = stIdle;
    runTimer  = '0;
    found     = 1'b0;
    searchIdx = 0;
    startIdx  = isIdle ? 0 : curIdx + 1;
    if (!isIdle && req[curIdx] && !timesUp[curIdx])
    begin
      nextState        = state;
      runTimer[curIdx] = 1'b1;
    end
    else
    begin
      // Current owner comes up last after the wrap
      for (int k = 0; k < NumPorts; k++)
      begin
        searchIdx = (startIdx + k) % NumPorts;
        if (!found && req[searchIdx])
        begin
          found     = 1'b1;
          nextState = toState(searchIdx);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

endmodule

//--- flitCrossbar.sv
`timescale 1ns/1ps

module flitCrossbar
  import nocPkg::*;
  import arbPkg::*;
#(
  parameter int DataWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  arbStateT             state,
  input  logic                 lReq,
  input  logic [DataWidth-1:0] lData,
  input  flitIdT               lFlitId,
  input  logic                 nReq,
  input  logic [DataWidth-1:0] nData,
  input  flitIdT               nFlitId,
  input  logic                 eReq,
  input  logic [DataWidth-1:0] eData,
  input  flitIdT               eFlitId,
  input  logic                 wReq,
  input  logic [DataWidth-1:0] wData,
  input  flitIdT               wFlitId,
  input  logic                 sReq,
  input  logic [DataWidth-1:0] sData,
  input  flitIdT               sFlitId,
  output logic [DataWidth-1:0] outData,
  output flitIdT               outFlitId,
  output logic                 outValid,
  output portT                 outPort
);

  logic                 selReq;
  logic [DataWidth-1:0] selData;
  flitIdT               selFlitId;
  portT                 selPort;

  // One-hot grant to port select
  always_comb
  begin
    selReq    = 1'b0;
    selData   = lData;
    selFlitId = lFlitId;
    selPort   = portL;
    case (state)
      stL:
      begin
        selReq = lReq;
      end
      stN:
      begin
        selReq    = nReq;
        selData   = nData;
        selFlitId = nFlitId;
        selPort   = portN;
      end
      stE:
      begin
        selReq    = eReq;
        selData   = eData;
        selFlitId = eFlitId;
        selPort   = portE;
      end
      stW:
      begin
        selReq    = wReq;
        selData   = wData;
        selFlitId = wFlitId;
        selPort   = portW;
      end
      stS:
      begin
        selReq    = sReq;
        selData   = sData;
        selFlitId = sFlitId;
        selPort   = portS;
      end
      default:
      begin
        selReq = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= portL;
    end
    else
    begin
      outValid <= selReq;
      if (selReq)
        outPort <= selPort;
    end
  end

  // Flit payload, held between windows
  always_ff @(posedge clk)
  begin
    if (selReq)
    begin
      outData   <= selData;
      outFlitId <= selFlitId;
    end
  end

endmodule

//--- outputPort.sv
`timescale 1ns/1ps

module outputPort
  import nocPkg::*;
  import arbPkg::*;
#(
  parameter int DataWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lReq,
  input  flitIdT               lFlitId,
  input  logic [LenWidth-1:0]  lLength,
  input  logic [DataWidth-1:0] lData,
  input  logic                 nReq,
  input  flitIdT               nFlitId,
  input  logic [LenWidth-1:0]  nLength,
  input  logic [DataWidth-1:0] nData,
  input  logic                 eReq,
  input  flitIdT               eFlitId,
  input  logic [LenWidth-1:0]  eLength,
  input  logic [DataWidth-1:0] eData,
  input  logic                 wReq,
  input  flitIdT               wFlitId,
  input  logic [LenWidth-1:0]  wLength,
  input  logic [DataWidth-1:0] wData,
  input  logic                 sReq,
  input  flitIdT               sFlitId,
  input  logic [LenWidth-1:0]  sLength,
  input  logic [DataWidth-1:0] sData,
  output logic [DataWidth-1:0] outData,
  output flitIdT               outFlitId,
  output logic                 outValid,
  output portT                 outPort
);

  // Registered grant
  arbStateT state;

  switchArbiter uArbiter (
    .clk     (clk),
    .rst     (rst),
    .lReq    (lReq),
    .lFlitId (lFlitId),
    .lLength (lLength),
    .nReq    (nReq),
    .nFlitId (nFlitId),
    .nLength (nLength),
    .eReq    (eReq),
    .eFlitId (eFlitId),
    .eLength (eLength),
    .wReq    (wReq),
    .wFlitId (wFlitId),
    .wLength (wLength),
    .sReq    (sReq),
    .sFlitId (sFlitId),
    .sLength (sLength),
    .state   (state)
  );

  flitCrossbar #(
    .DataWidth (DataWidth)
  ) uCrossbar (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .lReq      (lReq),
    .lData     (lData),
    .lFlitId   (lFlitId),
    .nReq      (nReq),
    .nData     (nData),
    .nFlitId   (nFlitId),
    .eReq      (eReq),
    .eData     (eData),
    .eFlitId   (eFlitId),
    .wReq      (wReq),
    .wData     (wData),
    .wFlitId   (wFlitId),
    .sReq      (sReq),
    .sData     (sData),
    .sFlitId   (sFlitId),
    .outData   (outData),
    .outFlitId (outFlitId),
    .outValid  (outValid),
    .outPort   (outPort)
  );

endmodule

//--- outputPort_asserts.sv
`timescale 1ns/1ps

module outputPort_asserts
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input logic lReq,
  input logic nReq,
  input logic eReq,
  input logic wReq,
  input logic sReq,
  input logic outValid,
  input portT outPort
);

  logic [NumPorts-1:0] reqDly;

  // Requests as seen one cycle back
  always_ff @(posedge clk)
    reqDly <= {sReq, wReq, eReq, nReq, lReq};

  validReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high after a reset cycle");

  portRange: assert property (@(posedge clk) disable iff (rst) outPort <= portS)
    else $error("outPort outside the five ports");

  validHasReq: assert property (@(posedge clk) disable iff (rst) outValid |-> reqDly[outPort])
    else $error("outValid for a port that was not requesting");

endmodule

bind outputPort outputPort_asserts uAsserts (
  .clk      (clk),
  .rst      (rst),
  .lReq     (lReq),
  .nReq     (nReq),
  .eReq     (eReq),
  .wReq     (wReq),
  .sReq     (sReq),
  .outValid (outValid),
  .outPort  (outPort)
);

//--- tb_outputPort.sv
`timescale 1ns/1ps

module tb_outputPort
  import nocPkg::*;
  import arbPkg::*;
();

  localparam int DataWidth = 16;
  localparam int MaxTests = 16;

  logic                 clk;
  logic                 rst;
  logic [4:0]           req;
  flitIdT               fid [NumPorts];
  logic [LenWidth-1:0]  len [NumPorts];
  logic [DataWidth-1:0] data [NumPorts];
  logic [DataWidth-1:0] outData;
  flitIdT               outFlitId;
  logic                 outValid;
  portT                 outPort;
  logic [31:0]          lfsr;
  int                   errors;
  int                   checks;
  int                   cycles;
  int                   limit;
  int                   numTests;
  // Kind, mask, five lengths, window count, then port and hold pairs
  int                   stim [MaxTests][20];

  outputPort #(
    .DataWidth (DataWidth)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .lReq (req[0]), .lFlitId (fid[0]), .lLength (len[0]), .lData (data[0]),
    .nReq (req[1]), .nFlitId (fid[1]), .nLength (len[1]), .nData (data[1]),
    .eReq (req[2]), .eFlitId (fid[2]), .eLength (len[2]), .eData (data[2]),
    .wReq (req[3]), .wFlitId (fid[3]), .wLength (len[3]), .wData (data[3]),
    .sReq (req[4]), .sFlitId (fid[4]), .sLength (len[4]), .sData (data[4]),
    .outData   (outData),
    .outFlitId (outFlitId),
    .outValid  (outValid),
    .outPort   (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic checkPort(input portT got, input portT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t: outPort %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic checkFlitId(input flitIdT got, input flitIdT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t: outFlitId %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic checkData(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t: outData %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("ERROR %0t: %s %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Check the flit on the output, then drive fresh payloads
  task automatic stepCycle();
    @(negedge clk);
    if (outValid)
    begin
      checkData(outData, data[outPort]);
      checkFlitId(outFlitId, fid[outPort]);
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      for (int b = 0; b < DataWidth; b++)
      begin
        lfsr = lfsrNext(lfsr);
        data[p][b] = lfsr[0];
      end
      lfsr = lfsrNext(lfsr);
      fid[p] = lfsr[0] ? tail : body;
    end
  endtask

  task automatic readStim();
    int fd;
    int n;
    string line;
    numTests = 0;
    fd = $fopen("outputPort_stim.txt", "r");
    while (fd != 0 && !$feof(fd) && numTests < MaxTests)
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%d %b %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
          stim[numTests][0], stim[numTests][1], stim[numTests][2], stim[numTests][3],
          stim[numTests][4], stim[numTests][5], stim[numTests][6], stim[numTests][7],
          stim[numTests][8], stim[numTests][9], stim[numTests][10], stim[numTests][11],
          stim[numTests][12], stim[numTests][13], stim[numTests][14], stim[numTests][15],
          stim[numTests][16], stim[numTests][17], stim[numTests][18], stim[numTests][19]);
        if (n >= 10)
        begin
          limit += 20;
          for (int w = 0; w < stim[numTests][7]; w++)
            limit += stim[numTests][9 + 2 * w];
          numTests++;
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
  endtask

  task automatic runTest(input int t);
    int kind;
    int count;
    int gap;
    int startErrors;
    portT expPort;
    kind = stim[t][0];
    startErrors = errors;
    // Head flits load every hold limit
    stepCycle();
    for (int p = 0; p < NumPorts; p++)
    begin
      fid[p] = head;
      len[p] = stim[t][2 + p];
    end
    stepCycle();
    req = stim[t][1][4:0];
    gap = 0;
    while (!outValid && gap < 4)
    begin
      gap++;
      stepCycle();
    end
    if (!outValid)
    begin
      errors++;
      $display("Test %0d: no grant appeared after the requests were raised", t);
    end
    for (int w = 0; w < stim[t][7]; w++)
    begin
      expPort = portT'(stim[t][8 + 2 * w]);
      checkPort(outPort, expPort);
      count = 0;
      while (outValid && outPort == expPort && !(kind == 0 && count == stim[t][9]))
      begin
        count++;
        // Early release ends the first window
        if (kind == 2 && w == 0 && count == stim[t][9])
          req[expPort] = 1'b0;
        stepCycle();
      end
      checkCount(count, stim[t][9 + 2 * w], "hold cycles");
      if (w < stim[t][7] - 1)
      begin
        gap = 0;
        while (!outValid && gap < 3)
        begin
          gap++;
          stepCycle();
        end
        checkCount(gap, (kind == 2 && w == 0) ? 1 : 0, "gap cycles");
      end
    end
    // All requests drop, output goes quiet
    req = '0;
    gap = 0;
    while (outValid && gap < 3)
    begin
      gap++;
      stepCycle();
    end
    if (gap > 2)
    begin
      errors++;
      $display("Test %0d: outValid still high two cycles after all requests dropped", t);
    end
    count = 0;
    for (int k = 0; k < 4; k++)
    begin
      stepCycle();
      count += outValid;
    end
    checkCount(count, 0, "valid cycles after idle");
    $display("Test %0d kind %0d finished with %0d errors", t, kind, errors - startErrors);
  endtask

  initial
  begin
    rst = 1'b1;
    req = '0;
    lfsr = 32'h5511_eb54;
    errors = 0;
    checks = 0;
    limit = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      fid[p] = none;
      len[p] = '0;
      data[p] = '0;
    end
    readStim();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (numTests == 0)
    begin
      errors++;
      $display("No tests could be read from outputPort_stim.txt");
    end
    for (int t = 0; t < numTests; t++)
      runTest(t);
    $display("Tests %0d, checks %0d, errors %0d", numTests, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Cycle budget from the stimulus file
  initial
  begin
    cycles = 0;
    wait (limit > 0);
    while (cycles <= limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Simulation timed out after %0d cycles", cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- outputPort_stim.txt
# kind mask(S W E N L) lenL lenN lenE lenW lenS windows, then port and hold per window
# kind 0 single request held, 1 rotation from idle, 2 early release; ports L0 N1 E2 W3 S4
0 00001 2 0 0 0 0 1 0 12
0 00100 0 0 3 0 0 1 2 9
0 10000 0 0 0 0 1 1 4 7
0 01000 0 0 0 0 0 1 3 5
1 11100 5 5 0 2 1 4 2 1 3 3 4 2 2 1
1 00110 3 1 2 0 0 3 1 2 2 3 1 2
1 11111 1 2 3 4 5 6 0 2 1 3 2 4 3 5 4 6 0 2
1 11111 0 3 0 1 2 6 0 1 1 4 2 1 3 2 4 3 0 1
1 11010 2 3 1 0 4 4 1 4 3 1 4 5 1 4
2 11111 6 5 4 3 2 3 0 3 1 6 2 5
2 10101 4 0 1 0 3 4 0 2 2 2 4 4 2 2
2 01110 0 8 2 0 0 4 1 1 2 3 3 1 2 3

//--- flist.f
nocPkg.sv
arbPkg.sv
portTimer.sv
switchArbiter.sv
flitCrossbar.sv
outputPort.sv
outputPort_asserts.sv
tb_outputPort.sv
